/* all.f */
+incdir+source
source/qdr_pkg.sv
source/qdr_req_if.sv
source/qdr_req_queue.sv
source/qdr_calib.sv
source/qdr_cmd_sched.sv
source/qdr_rd_return.sv
source/qdr_controller.sv
dv/qdr_sram_model.sv
dv/qdr_controller_sva.sv
dv/tb_qdr_controller.sv

/* Bender.yml */
package:
  name: qdr_controller

export_include_dirs:
  - source

sources:
  - source/qdr_pkg.sv
  - source/qdr_req_if.sv
  - source/qdr_req_queue.sv
  - source/qdr_calib.sv
  - source/qdr_cmd_sched.sv
  - source/qdr_rd_return.sv
  - source/qdr_controller.sv
  - target: test
    files:
      - dv/qdr_sram_model.sv
      - dv/qdr_controller_sva.sv
      - dv/tb_qdr_controller.sv

/* dv/tb_qdr_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module tb_qdr_controller;

  localparam int AW      = `QDR_ADDR_WIDTH;
  localparam int DW      = `QDR_DATA_WIDTH;
  localparam int BW      = `QDR_BW_WIDTH;
  localparam int NADDR   = 8;
  localparam int TIMEOUT = 2000;

  logic              clk0 = 1'b0;
  logic              qdr_rst;
  logic              idelay_rdy;
  logic              usr_rd_strb;
  logic              usr_wr_strb;
  logic [AW-1:0]     usr_addr;
  logic [2*DW-1:0]   usr_wr_data;
  logic [2*BW-1:0]   usr_wr_be;
  logic              fault;
  logic              usr_credit;
  logic [2*DW-1:0]   usr_rd_data;
  logic              usr_rd_dvld;
  logic              phy_rdy;
  logic              cal_fail;
  logic [DW-1:0]     qdr_d;
  logic [AW-1:0]     qdr_sa;
  logic              qdr_w_n;
  logic              qdr_r_n;
  logic [BW-1:0]     qdr_bw_n;
  logic [DW-1:0]     qdr_q;
  logic              qdr_qvld;

  logic [31:0]       lfsr = 32'hd416_077b;
  logic [2*DW-1:0]   ref_mem [int];
  logic [2*DW-1:0]   exp_mem [16];
  logic [3:0]        exp_wr = '0;
  logic [3:0]        exp_rd = '0;
  logic [AW-1:0]     addr_list [NADDR];
  string             test_name = "reset";
  int                errors = 0;
  int                errs_at_start;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                strobes_sent = 0;
  int                credits_back = 0;
  int                reads_sent = 0;
  int                reads_back = 0;
  int                base;
  int                n;

  always #20 clk0 = ~clk0;

  qdr_controller u_dut (.*);

  qdr_sram_model u_sram (
    .clk0     (clk0),
    .qdr_rst  (qdr_rst),
    .fault    (fault),
    .qdr_d    (qdr_d),
    .qdr_sa   (qdr_sa),
    .qdr_w_n  (qdr_w_n),
    .qdr_r_n  (qdr_r_n),
    .qdr_bw_n (qdr_bw_n),
    .qdr_q    (qdr_q),
    .qdr_qvld (qdr_qvld)
  );

  always @(posedge clk0) begin
    if (usr_credit) begin
      credits_back <= credits_back + 1;
    end
    if (usr_rd_dvld) begin
      reads_back <= reads_back + 1;
      exp_rd     <= exp_rd + 1'b1;
    end
  end

  // Returned words follow issue order
  a_rd_expected: assert property (@(posedge clk0) disable iff (qdr_rst || !idelay_rdy)
    usr_rd_dvld |-> exp_rd != exp_wr)
    else begin
      errors++;
      $display("Read data returned during %s with no read outstanding", test_name);
    end

  a_rd_data: assert property (@(posedge clk0) disable iff (qdr_rst || !idelay_rdy)
    usr_rd_dvld |-> usr_rd_data === exp_mem[exp_rd])
    else begin
      errors++;
      $display("ERROR %s: read data expected %h, actual %h", test_name,
               $sampled(exp_mem[exp_rd]), $sampled(usr_rd_data));
    end

  a_credit_owed: assert property (@(posedge clk0) disable iff (qdr_rst || !idelay_rdy)
    usr_credit |-> credits_back < strobes_sent)
    else begin
      errors++;
      $display("Credit returned during %s with no request outstanding", test_name);
    end

  // Galois LFSR, one step per bit
  function automatic logic [2*DW-1:0] take_bits(input int nbits);
    logic [2*DW-1:0] v;
    int              k;
    v = '0;
    for (k = 0; k < nbits; k++) begin
      v    = {v[2*DW-2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [2*DW-1:0] merge_lanes(input logic [2*DW-1:0] old,
                                                   input logic [2*DW-1:0] data,
                                                   input logic [2*BW-1:0] be);
    logic [2*DW-1:0] w;
    int              k;
    w = old;
    for (k = 0; k < 2*BW; k++) begin
      if (be[k]) begin
        w[k*9 +: 9] = data[k*9 +: 9];
      end
    end
    return w;
  endfunction

  function automatic int error_total();
    return errors + u_dut.u_sva.sva_errors;
  endfunction

  task automatic check_bit(input string what, input logic exp_val, input logic act_val);
    assert (act_val === exp_val) else begin
      errors++;
      $display("ERROR %s: %s expected %b, actual %b", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errs_at_start = error_total();
  endtask

  task automatic end_test();
    tests_run++;
    if (error_total() != errs_at_start) begin
      tests_failed++;
      $display("Test %s: fail, %0d errors", test_name, error_total() - errs_at_start);
    end else begin
      $display("Test %s: ok", test_name);
    end
  endtask

  task automatic wait_for_cal_end();
    int t;
    t = 0;
    while (!(phy_rdy || cal_fail) && t < TIMEOUT) begin
      @(negedge clk0);
      t++;
    end
    if (!(phy_rdy || cal_fail)) begin
      errors++;
      $display("Calibration did not finish in time during %s", test_name);
    end
  endtask

  task automatic wait_for_credit(output bit ok);
    int t;
    t = 0;
    while (strobes_sent - credits_back >= `QDR_CREDITS && t < TIMEOUT) begin
      @(negedge clk0);
      t++;
    end
    ok = (strobes_sent - credits_back < `QDR_CREDITS);
    if (!ok) begin
      errors++;
      $display("No user credit came back in time during %s", test_name);
    end
  endtask

  task automatic wait_for_idle();
    int t;
    t = 0;
    while ((credits_back != strobes_sent || reads_back != reads_sent) && t < TIMEOUT) begin
      @(negedge clk0);
      t++;
    end
    if (credits_back != strobes_sent || reads_back != reads_sent) begin
      errors++;
      $display("Requests still outstanding at the timeout during %s", test_name);
    end
  endtask

  // Called just after a falling edge, holds the strobe for one cycle
  task automatic issue_req(input logic wr, input logic [AW-1:0] addr,
                           input logic [2*DW-1:0] data, input logic [2*BW-1:0] be);
    logic [2*DW-1:0] cur;
    bit              ok;
    wait_for_credit(ok);
    if (!ok) begin
      return;
    end
    usr_wr_strb = wr;
    usr_rd_strb = !wr;
    usr_addr    = addr;
    usr_wr_data = data;
    usr_wr_be   = be;
    strobes_sent++;
    cur = ref_mem.exists(int'(addr)) ? ref_mem[int'(addr)] : '0;
    if (wr) begin
      ref_mem[int'(addr)] = merge_lanes(cur, data, be);
    end else begin
      exp_mem[exp_wr] = cur;
      exp_wr          = exp_wr + 1'b1;
      reads_sent++;
    end
    @(negedge clk0);
    usr_wr_strb = 1'b0;
    usr_rd_strb = 1'b0;
  endtask

  initial begin
    qdr_rst     = 1'b1;
    idelay_rdy  = 1'b1;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr    = '0;
    usr_wr_data = '0;
    usr_wr_be   = '0;
    fault       = 1'b0;

    start_test("calibration");
    repeat (16) @(negedge clk0);
    check_bit("qdr_w_n in reset", 1'b1, qdr_w_n);
    check_bit("qdr_r_n in reset", 1'b1, qdr_r_n);
    check_bit("usr_credit in reset", 1'b0, usr_credit);
    check_bit("usr_rd_dvld in reset", 1'b0, usr_rd_dvld);
    check_bit("phy_rdy in reset", 1'b0, phy_rdy);
    check_bit("cal_fail in reset", 1'b0, cal_fail);
    qdr_rst = 1'b0;
    wait_for_cal_end();
    check_bit("phy_rdy", 1'b1, phy_rdy);
    check_bit("cal_fail", 1'b0, cal_fail);
    // Training word left at address zero
    ref_mem[0] = `QDR_CAL_PATTERN;
    issue_req(1'b0, '0, '0, '0);
    wait_for_idle();
    end_test();

    start_test("full_word");
    for (n = 0; n < NADDR; n++) begin
      addr_list[n] = AW'(take_bits(AW));
      issue_req(1'b1, addr_list[n], take_bits(2*DW), '1);
    end
    for (n = 0; n < NADDR; n++) begin
      issue_req(1'b0, addr_list[n], '0, '0);
    end
    wait_for_idle();
    end_test();

    start_test("byte_lanes");
    for (n = 0; n < NADDR; n++) begin
      issue_req(1'b1, addr_list[n], take_bits(2*DW), (2*BW)'(take_bits(2*BW)));
    end
    for (n = 0; n < NADDR; n++) begin
      issue_req(1'b0, addr_list[n], '0, '0);
    end
    wait_for_idle();
    end_test();

    start_test("credit_burst");
    base = credits_back;
    for (n = 0; n < `QDR_CREDITS; n++) begin
      issue_req(n < 2, addr_list[n], take_bits(2*DW), '1);
    end
    wait_for_idle();
    repeat (8) @(negedge clk0);
    assert (credits_back - base == `QDR_CREDITS) else begin
      errors++;
      $display("ERROR %s: credit pulses expected %0d, actual %0d", test_name,
               `QDR_CREDITS, credits_back - base);
    end
    end_test();

    start_test("idelay_hold");
    idelay_rdy = 1'b0;
    repeat (10) begin
      @(negedge clk0);
      check_bit("phy_rdy while held", 1'b0, phy_rdy);
      check_bit("qdr_w_n while held", 1'b1, qdr_w_n);
      check_bit("qdr_r_n while held", 1'b1, qdr_r_n);
    end
    idelay_rdy = 1'b1;
    wait_for_cal_end();
    check_bit("phy_rdy", 1'b1, phy_rdy);
    check_bit("cal_fail", 1'b0, cal_fail);
    issue_req(1'b0, addr_list[0], '0, '0);
    wait_for_idle();
    end_test();

    start_test("cal_fault");
    fault   = 1'b1;
    qdr_rst = 1'b1;
    repeat (16) @(negedge clk0);
    qdr_rst = 1'b0;
    wait_for_cal_end();
    check_bit("cal_fail", 1'b1, cal_fail);
    check_bit("phy_rdy", 1'b0, phy_rdy);
    end_test();

    $display("Tests run %0d, failed %0d, check errors %0d, protocol errors %0d",
             tests_run, tests_failed, errors, u_dut.u_sva.sva_errors);
    if (error_total() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/qdr_controller_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module qdr_controller_sva (
  input wire clk0,
  input wire rst,
  input wire usr_rd_strb,
  input wire usr_wr_strb,
  input wire usr_credit,
  input wire phy_rdy,
  input wire qdr_w_n,
  input wire qdr_r_n
);

  int outstanding;
  int sva_errors = 0;

  // Requests the user holds against the controller
  always @(posedge clk0) begin
    if (rst) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(usr_rd_strb || usr_wr_strb) - int'(usr_credit);
    end
  end

  a_cmd_apart: assert property (@(posedge clk0) disable iff (rst)
    !($fell(qdr_w_n) && $fell(qdr_r_n)))
    else begin
      sva_errors++;
      $error("qdr_w_n and qdr_r_n fell in the same cycle");
    end

  a_strobe_credit: assert property (@(posedge clk0) disable iff (rst)
    (usr_rd_strb || usr_wr_strb) |-> phy_rdy && (outstanding < `QDR_CREDITS))
    else begin
      sva_errors++;
      $error("user strobe without a credit");
    end

  a_credit_bound: assert property (@(posedge clk0) disable iff (rst)
    (outstanding >= 0) && (outstanding <= `QDR_CREDITS))
    else begin
      sva_errors++;
      $error("outstanding credits out of range");
    end

endmodule

bind qdr_controller qdr_controller_sva u_sva (.*);

`default_nettype wire

/* dv/qdr_sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module qdr_sram_model (
  input  wire                         clk0,
  input  wire                         qdr_rst,
  input  wire                         fault,
  input  wire [`QDR_DATA_WIDTH-1:0]   qdr_d,
  input  wire [`QDR_ADDR_WIDTH-1:0]   qdr_sa,
  input  wire                         qdr_w_n,
  input  wire                         qdr_r_n,
  input  wire [`QDR_BW_WIDTH-1:0]     qdr_bw_n,
  output logic [`QDR_DATA_WIDTH-1:0]  qdr_q,
  output logic                        qdr_qvld
);

  localparam int DW     = `QDR_DATA_WIDTH;
  localparam int BW     = `QDR_BW_WIDTH;
  localparam int LANE   = DW / BW;
  localparam int STAGES = `QDR_RD_LATENCY - 1;

  // Sparse storage, one two-beat word per address
  logic [2*DW-1:0]    mem [int];
  logic               wr_hi;
  int                 wr_addr;
  logic [STAGES-1:0]  rd_vld;
  int                 rd_addr [STAGES];
  logic               rd_hi;
  int                 rd_hi_addr;
  int                 s;

  task automatic write_lanes(input int a, input int half);
    logic [2*DW-1:0] w;
    int              k;
    w = mem.exists(a) ? mem[a] : '0;
    for (k = 0; k < BW; k++) begin
      if (!qdr_bw_n[k]) begin
        w[(half*BW+k)*LANE +: LANE] = qdr_d[k*LANE +: LANE];
      end
    end
    mem[a] = w;
  endtask

  function automatic logic [DW-1:0] read_half(input int a, input int half);
    logic [2*DW-1:0] w;
    w = mem.exists(a) ? mem[a] : '0;
    // Fault flips bit 0 of every returned beat
    return w[half*DW +: DW] ^ {{(DW-1){1'b0}}, fault};
  endfunction

  always @(posedge clk0) begin
    if (qdr_rst) begin
      wr_hi    <= 1'b0;
      rd_vld   <= '0;
      rd_hi    <= 1'b0;
      qdr_qvld <= 1'b0;
      qdr_q    <= '0;
    end else begin
      if (!qdr_w_n) begin
        write_lanes(int'(qdr_sa), 0);
      end
      if (wr_hi) begin
        write_lanes(wr_addr, 1);
      end
      wr_hi   <= !qdr_w_n;
      wr_addr <= int'(qdr_sa);
      for (s = STAGES - 1; s > 0; s--) begin
        rd_vld[s]  <= rd_vld[s-1];
        rd_addr[s] <= rd_addr[s-1];
      end
      rd_vld[0]  <= !qdr_r_n;
      rd_addr[0] <= int'(qdr_sa);
      rd_hi      <= rd_vld[STAGES-1];
      rd_hi_addr <= rd_addr[STAGES-1];
      qdr_qvld   <= rd_vld[STAGES-1] || rd_hi;
      if (rd_vld[STAGES-1]) begin
        qdr_q <= read_half(rd_addr[STAGES-1], 0);
      end else if (rd_hi) begin
        qdr_q <= read_half(rd_hi_addr, 1);
      end
    end
  end

endmodule

`default_nettype wire

/* source/qdr_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module qdr_controller (
  input  wire                           clk0,
  input  wire                           qdr_rst,
  input  wire                           idelay_rdy,
  input  wire                           usr_rd_strb,
  input  wire                           usr_wr_strb,
  input  wire [`QDR_ADDR_WIDTH-1:0]     usr_addr,
  input  wire [2*`QDR_DATA_WIDTH-1:0]   usr_wr_data,
  input  wire [2*`QDR_BW_WIDTH-1:0]     usr_wr_be,
  output logic                          usr_credit,
  output logic [2*`QDR_DATA_WIDTH-1:0]  usr_rd_data,
  output logic                          usr_rd_dvld,
  output logic                          phy_rdy,
  output logic                          cal_fail,
  output logic [`QDR_DATA_WIDTH-1:0]    qdr_d,
  output logic [`QDR_ADDR_WIDTH-1:0]    qdr_sa,
  output logic                          qdr_w_n,
  output logic                          qdr_r_n,
  output logic [`QDR_BW_WIDTH-1:0]      qdr_bw_n,
  input  wire [`QDR_DATA_WIDTH-1:0]     qdr_q,
  input  wire                           qdr_qvld
);

  logic                          rst;
  logic                          cal_req;
  logic                          cal_wr;
  logic                          cal_busy;
  logic [2*`QDR_DATA_WIDTH-1:0]  cal_rd_data;
  logic                          cal_rd_vld;
  logic                          rd_issue;
  logic                          rd_is_cal;

  // Held in reset until the delay elements report ready
  assign rst = qdr_rst || !idelay_rdy;

  qdr_req_if u_req_if ();

  qdr_req_queue u_req_queue (
    .clk0        (clk0),
    .rst         (rst),
    .usr_rd_strb (usr_rd_strb),
    .usr_wr_strb (usr_wr_strb),
    .usr_addr    (usr_addr),
    .usr_wr_data (usr_wr_data),
    .usr_wr_be   (usr_wr_be),
    .usr_credit  (usr_credit),
    .req_if      (u_req_if.source)
  );

  qdr_calib u_calib (
    .clk0        (clk0),
    .rst         (rst),
    .cal_req     (cal_req),
    .cal_wr      (cal_wr),
    .cal_busy    (cal_busy),
    .cal_rd_data (cal_rd_data),
    .cal_rd_vld  (cal_rd_vld),
    .phy_rdy     (phy_rdy),
    .cal_fail    (cal_fail)
  );

  qdr_cmd_sched u_cmd_sched (
    .clk0      (clk0),
    .rst       (rst),
    .req_if    (u_req_if.sink),
    .phy_rdy   (phy_rdy),
    .cal_req   (cal_req),
    .cal_wr    (cal_wr),
    .cal_busy  (cal_busy),
    .qdr_d     (qdr_d),
    .qdr_sa    (qdr_sa),
    .qdr_w_n   (qdr_w_n),
    .qdr_r_n   (qdr_r_n),
    .qdr_bw_n  (qdr_bw_n),
    .rd_issue  (rd_issue),
    .rd_is_cal (rd_is_cal)
  );

  qdr_rd_return u_rd_return (
    .clk0        (clk0),
    .rst         (rst),
    .rd_issue    (rd_issue),
    .rd_is_cal   (rd_is_cal),
    .qdr_q       (qdr_q),
    .qdr_qvld    (qdr_qvld),
    .cal_rd_data (cal_rd_data),
    .cal_rd_vld  (cal_rd_vld),
    .usr_rd_data (usr_rd_data),
    .usr_rd_dvld (usr_rd_dvld)
  );

endmodule

`default_nettype wire

/* source/qdr_rd_return.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module qdr_rd_return (
  input  wire                           clk0,
  input  wire                           rst,
  input  wire                           rd_issue,
  input  wire                           rd_is_cal,
  input  wire [`QDR_DATA_WIDTH-1:0]     qdr_q,
  input  wire                           qdr_qvld,
  output logic [2*`QDR_DATA_WIDTH-1:0]  cal_rd_data,
  output logic                          cal_rd_vld,
  output logic [2*`QDR_DATA_WIDTH-1:0]  usr_rd_data,
  output logic                          usr_rd_dvld
);

  localparam int PTR_W = $clog2(`QDR_CREDITS);

  // Tag per outstanding read, set for calibration reads
  logic                          tag_mem [`QDR_CREDITS];
  logic [PTR_W-1:0]              tag_wr;
  logic [PTR_W-1:0]              tag_rd;
  logic                          beat_hi;
  logic [`QDR_DATA_WIDTH-1:0]    lo_half;
  logic [2*`QDR_DATA_WIDTH-1:0]  word;
  logic                          done;

  assign done        = qdr_qvld && beat_hi;
  assign cal_rd_data = word;
  assign usr_rd_data = word;

  always_ff @(posedge clk0) begin
    if (rd_issue) begin
      tag_mem[tag_wr] <= rd_is_cal;
    end
    if (qdr_qvld && !beat_hi) begin
      lo_half <= qdr_q;
    end
    if (done) begin
      word <= {qdr_q, lo_half};
    end
  end

  always_ff @(posedge clk0) begin
    if (rst) begin
      tag_wr      <= '0;
      tag_rd      <= '0;
      beat_hi     <= 1'b0;
      cal_rd_vld  <= 1'b0;
      usr_rd_dvld <= 1'b0;
    end else begin
      if (rd_issue) begin
        tag_wr <= tag_wr + 1'b1;
      end
      if (qdr_qvld) begin
        beat_hi <= !beat_hi;
      end
      if (done) begin
        tag_rd <= tag_rd + 1'b1;
      end
      cal_rd_vld  <= done && tag_mem[tag_rd];
      usr_rd_dvld <= done && !tag_mem[tag_rd];
    end
  end

endmodule

`default_nettype wire

/* source/qdr_cmd_sched.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module qdr_cmd_sched import qdr_pkg::*; (
  input  wire                         clk0,
  input  wire                         rst,
  qdr_req_if.sink                     req_if,
  input  wire                         phy_rdy,
  input  wire                         cal_req,
  input  wire                         cal_wr,
  output logic                        cal_busy,
  output logic [`QDR_DATA_WIDTH-1:0]  qdr_d,
  output logic [`QDR_ADDR_WIDTH-1:0]  qdr_sa,
  output logic                        qdr_w_n,
  output logic                        qdr_r_n,
  output logic [`QDR_BW_WIDTH-1:0]    qdr_bw_n,
  output logic                        rd_issue,
  output logic                        rd_is_cal
);

  localparam int PTR_W = $clog2(`QDR_CREDITS);
  localparam int CNT_W = $clog2(`QDR_CREDITS + 1);
  localparam int DW    = `QDR_DATA_WIDTH;
  localparam int BW    = `QDR_BW_WIDTH;

  qdr_req_t          pend_mem [`QDR_CREDITS];
  logic [PTR_W-1:0]  pend_wr;
  logic [PTR_W-1:0]  pend_rd;
  logic [CNT_W-1:0]  pend_cnt;
  // 0 idle, 1 first beat on the pins, 2 second beat on the pins
  logic [1:0]        ph;
  qdr_req_t          cur;
  logic              cur_cal;
  qdr_req_t          nxt;
  logic              start_cal;
  logic              start_usr;
  logic              start;

  // A new command may follow the second beat directly
  assign start_cal = !phy_rdy && cal_req && (ph != 2'd1);
  assign start_usr = phy_rdy && (pend_cnt != '0) && (ph != 2'd1);
  assign start     = start_cal | start_usr;

  always_comb begin
    if (start_cal) begin
      nxt.wr   = cal_wr;
      nxt.addr = '0;
      nxt.data = `QDR_CAL_PATTERN;
      nxt.be   = '1;
    end else begin
      nxt = pend_mem[pend_rd];
    end
  end

  assign req_if.credit = (ph == 2'd2) && !cur_cal;
  assign cal_busy      = (ph != 2'd0) && cur_cal;

  always_ff @(posedge clk0) begin
    if (req_if.valid) begin
      pend_mem[pend_wr] <= req_if.req;
    end
    if (start) begin
      cur <= nxt;
    end
  end

  always_ff @(posedge clk0) begin
    if (rst) begin
      pend_wr   <= '0;
      pend_rd   <= '0;
      pend_cnt  <= '0;
      ph        <= 2'd0;
      cur_cal   <= 1'b0;
      qdr_w_n   <= 1'b1;
      qdr_r_n   <= 1'b1;
      qdr_bw_n  <= '1;
      rd_issue  <= 1'b0;
      rd_is_cal <= 1'b0;
    end else begin
      if (req_if.valid) begin
        pend_wr <= pend_wr + 1'b1;
      end
      if (start_usr) begin
        pend_rd <= pend_rd + 1'b1;
      end
      pend_cnt <= pend_cnt + CNT_W'(req_if.valid) - CNT_W'(start_usr);
      rd_issue  <= start && !nxt.wr;
      rd_is_cal <= start_cal;
      if (start) begin
        ph       <= 2'd1;
        cur_cal  <= start_cal;
        qdr_sa   <= nxt.addr;
        qdr_d    <= nxt.data[DW-1:0];
        qdr_bw_n <= nxt.wr ? ~nxt.be[BW-1:0] : '1;
        qdr_w_n  <= !nxt.wr;
        qdr_r_n  <= nxt.wr;
      end else if (ph == 2'd1) begin
        // Second beat carries the high half on the same address
        ph       <= 2'd2;
        qdr_d    <= cur.data[2*DW-1:DW];
        qdr_bw_n <= cur.wr ? ~cur.be[2*BW-1:BW] : '1;
        qdr_w_n  <= 1'b1;
        qdr_r_n  <= 1'b1;
      end else begin
        ph       <= 2'd0;
        cur_cal  <= 1'b0;
        qdr_bw_n <= '1;
        qdr_w_n  <= 1'b1;
        qdr_r_n  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/qdr_calib.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module qdr_calib (
  input  wire                           clk0,
  input  wire                           rst,
  output logic                          cal_req,
  output logic                          cal_wr,
  input  wire                           cal_busy,
  input  wire [2*`QDR_DATA_WIDTH-1:0]   cal_rd_data,
  input  wire                           cal_rd_vld,
  output logic                          phy_rdy,
  output logic                          cal_fail
);

  localparam int TRY_W = $clog2(`QDR_CAL_TRIES);

  typedef enum logic [2:0] {
    CAL_WR_REQ,
    CAL_WR_WAIT,
    CAL_RD_REQ,
    CAL_RD_WAIT,
    CAL_DONE,
    CAL_FAIL
  } cal_state_t;

  cal_state_t        state;
  logic [TRY_W-1:0]  tries;

  assign cal_req  = (state == CAL_WR_REQ) || (state == CAL_RD_REQ);
  assign cal_wr   = (state == CAL_WR_REQ);
  assign phy_rdy  = (state == CAL_DONE);
  assign cal_fail = (state == CAL_FAIL);

  always_ff @(posedge clk0) begin
    if (rst) begin
      state <= CAL_WR_REQ;
      tries <= '0;
    end else begin
      case (state)
        CAL_WR_REQ:  if (cal_busy) state <= CAL_WR_WAIT;
        CAL_WR_WAIT: if (!cal_busy) state <= CAL_RD_REQ;
        CAL_RD_REQ:  if (cal_busy) state <= CAL_RD_WAIT;
        CAL_RD_WAIT: begin
          if (cal_rd_vld) begin
            if (cal_rd_data == `QDR_CAL_PATTERN) begin
              state <= CAL_DONE;
            end else if (tries == TRY_W'(`QDR_CAL_TRIES - 1)) begin
              state <= CAL_FAIL;
            end else begin
              // Write the pattern again before the next read
              tries <= tries + 1'b1;
              state <= CAL_WR_REQ;
            end
          end
        end
        // Done and fail hold until reset
        default: state <= state;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/qdr_req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

module qdr_req_queue import qdr_pkg::*; (
  input  wire                           clk0,
  input  wire                           rst,
  input  wire                           usr_rd_strb,
  input  wire                           usr_wr_strb,
  input  wire [`QDR_ADDR_WIDTH-1:0]     usr_addr,
  input  wire [2*`QDR_DATA_WIDTH-1:0]   usr_wr_data,
  input  wire [2*`QDR_BW_WIDTH-1:0]     usr_wr_be,
  output logic                          usr_credit,
  qdr_req_if.source                     req_if
);

  localparam int PTR_W = $clog2(`QDR_CREDITS);
  localparam int CNT_W = $clog2(`QDR_CREDITS + 1);

  qdr_req_t           fifo_mem [`QDR_CREDITS];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   fifo_cnt;
  logic [CNT_W-1:0]   sched_cred;
  logic               push;
  logic               pop;

  assign push = usr_rd_strb | usr_wr_strb;
  // Present only while the scheduler has room for another request
  assign pop  = (fifo_cnt != '0) && (sched_cred != '0);

  assign req_if.valid = pop;
  assign req_if.req   = fifo_mem[rd_ptr];

  always_ff @(posedge clk0) begin
    if (push) begin
      fifo_mem[wr_ptr] <= '{wr: usr_wr_strb, addr: usr_addr, data: usr_wr_data, be: usr_wr_be};
    end
  end

  always_ff @(posedge clk0) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_cnt   <= '0;
      sched_cred <= CNT_W'(`QDR_CREDITS);
      usr_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_cnt   <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
      sched_cred <= sched_cred + CNT_W'(req_if.credit) - CNT_W'(pop);
      // Entry retires once its command has left the pins
      usr_credit <= req_if.credit;
    end
  end

endmodule

`default_nettype wire

/* source/qdr_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_defines.svh"

interface qdr_req_if import qdr_pkg::*; ();

  logic     valid;
  qdr_req_t req;
  // One pulse per request the scheduler has finished issuing
  logic     credit;

  modport source (
    output valid,
    output req,
    input  credit
  );

  modport sink (
    input  valid,
    input  req,
    output credit
  );

endinterface

`default_nettype wire

/* source/qdr_pkg.sv */
`default_nettype none

`include "qdr_defines.svh"

package qdr_pkg;

  // One user or calibration request, data and enables cover both beats
  typedef struct packed {
    logic                            wr;
    logic [`QDR_ADDR_WIDTH-1:0]      addr;
    logic [2*`QDR_DATA_WIDTH-1:0]    data;
    logic [2*`QDR_BW_WIDTH-1:0]      be;
  } qdr_req_t;

endpackage

`default_nettype wire

/* source/qdr_defines.svh */
`ifndef QDR_DEFINES_SVH
`define QDR_DEFINES_SVH

// Memory beat geometry, one lane covers 9 bits
`define QDR_DATA_WIDTH 36
`define QDR_BW_WIDTH 4
`define QDR_ADDR_WIDTH 22

// Cycles from the read command beat to the first returned beat
`define QDR_RD_LATENCY 2

// Queue depth and user credit count
`define QDR_CREDITS 4

// Calibration
`define QDR_CAL_TRIES 3
`define QDR_CAL_PATTERN {8'h00, 64'habcd_ef12_3456_7890}

`endif
